// File: list.f
logic/tag_store_cfg_pkg.sv
logic/tag_store_types_pkg.sv
logic/tag_store_ctrl.sv
logic/tag_way_array.sv
logic/tag_compare.sv
logic/evict_select.sv
logic/result_spill.sv
logic/tag_store_top.sv
dv/tag_store_tb.sv

// File: Bender.yml
package:
  name: tag_store

sources:
  - logic/tag_store_cfg_pkg.sv
  - logic/tag_store_types_pkg.sv
  - logic/tag_store_ctrl.sv
  - logic/tag_way_array.sv
  - logic/tag_compare.sv
  - logic/evict_select.sv
  - logic/result_spill.sv
  - logic/tag_store_top.sv
  - target: simulation
    files:
      - dv/tag_store_tb.sv

// File: dv/tag_store_tb.sv
// Testbench for tag_store_top at read_latency 1; expected rows assume the DUT starts from reset
module tag_store_tb
  import tag_store_types_pkg::*;
();

  localparam int unsigned num_rows    = 28;
  localparam int unsigned cycle_limit = 8 * (num_rows * 3) + 8;

  // One table row with stimulus first and the expected response after it
  typedef struct packed {
    tag_mode_e mode;
    index_t    index;
    tag_t      tag;
    logic      dirty;
    way_vec_t  way;
    way_vec_t  lock;
    way_vec_t  exp_way;
    logic      exp_hit;
    logic      exp_evict;
    tag_t      exp_tag;
  } row_t;

  // mode, index, tag, dirty, way, lock, exp_way, exp_hit, exp_evict, exp_tag
  localparam row_t rows [num_rows] = '{
    // Set 5 takes a first miss, a back-to-back hit with dirty upgrade and two flushes
    '{mode_lookup, 6'd5,  10'h0a1, 1'b0, 4'b0000, 4'b0000, 4'b0001, 1'b0, 1'b0, 10'h000},
    '{mode_lookup, 6'd5,  10'h0a1, 1'b1, 4'b0000, 4'b0000, 4'b0001, 1'b1, 1'b0, 10'h000},
    '{mode_flush,  6'd5,  10'h000, 1'b0, 4'b0001, 4'b0000, 4'b0001, 1'b0, 1'b1, 10'h0a1},
    '{mode_flush,  6'd5,  10'h000, 1'b0, 4'b0001, 4'b0000, 4'b0001, 1'b0, 1'b0, 10'h000},
    // Set 12 fills all ways, then takes round-robin victims from way 0
    '{mode_lookup, 6'd12, 10'h100, 1'b1, 4'b0000, 4'b0000, 4'b0001, 1'b0, 1'b0, 10'h000},
    '{mode_lookup, 6'd12, 10'h101, 1'b0, 4'b0000, 4'b0000, 4'b0010, 1'b0, 1'b0, 10'h000},
    '{mode_lookup, 6'd12, 10'h102, 1'b1, 4'b0000, 4'b0000, 4'b0100, 1'b0, 1'b0, 10'h000},
    '{mode_lookup, 6'd12, 10'h103, 1'b0, 4'b0000, 4'b0000, 4'b1000, 1'b0, 1'b0, 10'h000},
    '{mode_lookup, 6'd12, 10'h104, 1'b0, 4'b0000, 4'b0000, 4'b0001, 1'b0, 1'b1, 10'h100},
    '{mode_lookup, 6'd12, 10'h105, 1'b1, 4'b0000, 4'b0000, 4'b0010, 1'b0, 1'b0, 10'h101},
    '{mode_lookup, 6'd12, 10'h106, 1'b0, 4'b0000, 4'b0000, 4'b0100, 1'b0, 1'b1, 10'h102},
    '{mode_lookup, 6'd12, 10'h104, 1'b0, 4'b0000, 4'b0000, 4'b0001, 1'b1, 1'b0, 10'h000},
    // Way 3 locked, so its tag misses and the pointer skips it
    '{mode_lookup, 6'd12, 10'h103, 1'b0, 4'b0000, 4'b1000, 4'b0001, 1'b0, 1'b0, 10'h104},
    '{mode_lookup, 6'd12, 10'h103, 1'b1, 4'b0000, 4'b1000, 4'b0001, 1'b1, 1'b0, 10'h000},
    '{mode_lookup, 6'd12, 10'h1ff, 1'b0, 4'b0000, 4'b1000, 4'b0010, 1'b0, 1'b1, 10'h105},
    '{mode_lookup, 6'd12, 10'h1fe, 1'b0, 4'b0000, 4'b1000, 4'b0100, 1'b0, 1'b0, 10'h106},
    '{mode_lookup, 6'd12, 10'h1fd, 1'b0, 4'b0000, 4'b1000, 4'b0001, 1'b0, 1'b1, 10'h103},
    '{mode_flush,  6'd12, 10'h000, 1'b0, 4'b1000, 4'b0000, 4'b1000, 1'b0, 1'b0, 10'h103},
    // Refill of the flushed way leaves the pointer on way 1 for the next full-set miss
    '{mode_lookup, 6'd12, 10'h1fc, 1'b0, 4'b0000, 4'b0000, 4'b1000, 1'b0, 1'b0, 10'h000},
    '{mode_lookup, 6'd12, 10'h1fb, 1'b0, 4'b0000, 4'b0000, 4'b0010, 1'b0, 1'b0, 10'h1ff},
    // In set 33 the free-way pick passes over a locked free way
    '{mode_lookup, 6'd33, 10'h2aa, 1'b1, 4'b0000, 4'b0010, 4'b0001, 1'b0, 1'b0, 10'h000},
    '{mode_lookup, 6'd33, 10'h2ab, 1'b0, 4'b0000, 4'b0010, 4'b0100, 1'b0, 1'b0, 10'h000},
    '{mode_flush,  6'd33, 10'h000, 1'b0, 4'b0001, 4'b0010, 4'b0001, 1'b0, 1'b1, 10'h2aa},
    // Edge sets 63 and 0
    '{mode_lookup, 6'd63, 10'h3ff, 1'b1, 4'b0000, 4'b0000, 4'b0001, 1'b0, 1'b0, 10'h000},
    '{mode_lookup, 6'd63, 10'h3ff, 1'b0, 4'b0000, 4'b0000, 4'b0001, 1'b1, 1'b0, 10'h000},
    '{mode_flush,  6'd63, 10'h000, 1'b0, 4'b0001, 4'b0000, 4'b0001, 1'b0, 1'b1, 10'h3ff},
    '{mode_lookup, 6'd0,  10'h000, 1'b0, 4'b0000, 4'b0000, 4'b0001, 1'b0, 1'b0, 10'h000},
    '{mode_lookup, 6'd0,  10'h000, 1'b1, 4'b0000, 4'b0000, 4'b0001, 1'b1, 1'b0, 10'h000}
  };

  logic     clk;
  logic     reset;
  tag_req_t req;
  logic     req_valid;
  logic     req_ready;
  tag_res_t res;
  logic     res_valid;
  logic     res_ready;
  way_vec_t spm_lock;

  int          error_count;
  int          rows_passed;
  int          rows_failed;
  logic [15:0] lfsr_q;

  tag_store_top #(
    .read_latency (1)
  ) dut0 (
    .clk_i      (clk),
    .reset_i    (reset),
    .req_i      (req),
    .valid_i    (req_valid),
    .ready_o    (req_ready),
    .res_o      (res),
    .valid_o    (res_valid),
    .ready_i    (res_ready),
    .spm_lock_i (spm_lock)
  );

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      error_count++;
    end
  endtask

  // Waits for idle, and for an empty result buffer when the lock mask changes
  task automatic apply_row(input row_t r);
    do begin
      @(posedge clk);
    end while (!req_ready || (r.lock != spm_lock && res_valid));
    req <= '{mode: r.mode, index: r.index, tag: r.tag, dirty: r.dirty, way: r.way};
    req_valid <= 1'b1;
    spm_lock  <= r.lock;
    // Accept edge
    do begin
      @(posedge clk);
    end while (!req_ready);
    req_valid <= 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Request side
  initial begin
    reset     = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    spm_lock  = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    compare_value("ready_o after reset", req_ready, 1);
    compare_value("valid_o after reset", res_valid, 0);
    for (int i = 0; i < num_rows; i++) begin
      apply_row(rows[i]);
    end
  end

  // Response side with random back-pressure, checking and the cycle limit
  initial begin
    int       rsp_idx;
    int       row_errors;
    int       cycles;
    logic     prev_valid;
    logic     prev_ready;
    tag_res_t prev_res;
    row_t     r;
    error_count = 0;
    rows_passed = 0;
    rows_failed = 0;
    rsp_idx     = 0;
    cycles      = 0;
    prev_valid  = 1'b0;
    prev_ready  = 1'b0;
    prev_res    = '0;
    lfsr_q      = 16'd15691;
    res_ready   = 1'b0;
    while (rsp_idx < num_rows && cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
      if (!reset) begin
        // A stalled response must stay put
        if (prev_valid && !prev_ready) begin
          compare_value("valid_o under back-pressure", res_valid, 1);
          compare_value("res_o under back-pressure", res, prev_res);
        end
        if (res_valid && res_ready) begin
          r          = rows[rsp_idx];
          row_errors = error_count;
          compare_value($sformatf("row %0d way", rsp_idx), res.way, r.exp_way);
          compare_value($sformatf("row %0d hit", rsp_idx), res.hit, r.exp_hit);
          compare_value($sformatf("row %0d evict", rsp_idx), res.evict, r.exp_evict);
          compare_value($sformatf("row %0d evict_tag", rsp_idx), res.evict_tag, r.exp_tag);
          if (error_count == row_errors) begin
            rows_passed++;
            $display("Row %0d passed", rsp_idx);
          end else begin
            rows_failed++;
            $display("Row %0d failed", rsp_idx);
          end
          rsp_idx++;
        end
      end
      prev_valid = res_valid;
      prev_ready = res_ready;
      prev_res   = res;
      lfsr_q     = lfsr_next(lfsr_q);
      res_ready <= lfsr_q[0];
    end
    if (rsp_idx < num_rows) begin
      $display("Timeout: %0d of %0d responses arrived within %0d cycles",
               rsp_idx, num_rows, cycle_limit);
    end else begin
      // No extra response may follow the last row
      repeat (4) @(posedge clk);
      compare_value("valid_o after last response", res_valid, 0);
    end
    $display("Rows passed: %0d, rows failed: %0d, errors: %0d",
             rows_passed, rows_failed, error_count);
    if (rsp_idx == num_rows && error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: logic/tag_store_top.sv
// Tag store top level; one request in flight at the array, spm_lock_i only changes while idle
module tag_store_top
  import tag_store_types_pkg::*;
#(
  parameter int unsigned read_latency = 1
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  tag_req_t req_i,
  input  logic     valid_i,
  output logic     ready_o,
  output tag_res_t res_o,
  output logic     valid_o,
  input  logic     ready_i,
  input  way_vec_t spm_lock_i
);

  // Controller to array read side
  logic           rd_en;
  index_t         rd_index;
  tag_entry_vec_t rdata;
  logic           rvalid;

  // Held request and result hand-off
  tag_req_t       req_q;
  logic           push;
  logic           push_ready;
  logic           commit;
  tag_res_t       res;
  logic           miss;

  // Write-back path
  way_vec_t       wr_en;
  index_t         wr_index;
  tag_entry_t     wdata;
  way_vec_t       victim;

  tag_store_ctrl u_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .valid_i      (valid_i),
    .ready_o      (ready_o),
    .rd_en_o      (rd_en),
    .rd_index_o   (rd_index),
    .rvalid_i     (rvalid),
    .req_q_o      (req_q),
    .push_o       (push),
    .push_ready_i (push_ready),
    .commit_o     (commit)
  );

  tag_way_array #(
    .read_latency (read_latency)
  ) u_array (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rd_en_i    (rd_en),
    .wr_en_i    (wr_en),
    .index_i    (rd_index),
    .wr_index_i (wr_index),
    .wdata_i    (wdata),
    .rdata_o    (rdata),
    .rvalid_o   (rvalid)
  );

  tag_compare u_compare (
    .req_q_i    (req_q),
    .rdata_i    (rdata),
    .spm_lock_i (spm_lock_i),
    .victim_i   (victim),
    .commit_i   (commit),
    .res_o      (res),
    .miss_o     (miss),
    .wr_en_o    (wr_en),
    .wr_index_o (wr_index),
    .wdata_o    (wdata)
  );

  evict_select u_evict (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rdata_i    (rdata),
    .spm_lock_i (spm_lock_i),
    .miss_i     (miss),
    .commit_i   (commit),
    .victim_o   (victim)
  );

  // Spill push is the commit, so a full buffer stalls the write-back too
  result_spill u_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (res),
    .valid_i (push),
    .ready_o (push_ready),
    .data_o  (res_o),
    .valid_o (valid_o),
    .ready_i (ready_i)
  );

endmodule

// File: logic/result_spill.sv
// Two-entry result FIFO with registered output; ready_o depends only on the fill level
module result_spill
  import tag_store_types_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  tag_res_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output tag_res_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  logic [1:0] count_q;
  tag_res_t   head_q;
  tag_res_t   tail_q;
  logic       push;
  logic       pop;

  assign ready_o = (count_q != 2'd2);
  assign valid_o = (count_q != 2'd0);
  assign data_o  = head_q;

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= 2'd0;
    end else if (push && !pop) begin
      count_q <= count_q + 2'd1;
    end else if (pop && !push) begin
      count_q <= count_q - 2'd1;
    end
  end

  // Head is the visible entry, tail the one queued behind it
  always_ff @(posedge clk_i) begin
    if (push && (count_q == 2'd0 || (count_q == 2'd1 && pop))) begin
      head_q <= data_i;
    end else if (pop && count_q == 2'd2) begin
      head_q <= tail_q;
    end
    // Second entry only fills when the head stays
    if (push && count_q == 2'd1 && !pop) begin
      tail_q <= data_i;
    end
  end

endmodule

// File: logic/evict_select.sv
// Victim choice for a lookup miss; with every way locked no victim is given and nothing is written
module evict_select
  import tag_store_cfg_pkg::*;
  import tag_store_types_pkg::*;
(
  input  logic           clk_i,
  input  logic           reset_i,
  input  tag_entry_vec_t rdata_i,
  input  way_vec_t       spm_lock_i,
  input  logic           miss_i,
  input  logic           commit_i,
  output way_vec_t       victim_o
);

  localparam int unsigned ptr_width = $clog2(num_ways);

  logic [ptr_width-1:0] ptr_q;
  logic [ptr_width-1:0] rr_idx;
  logic                 rr_found;
  way_vec_t             free_vec;
  way_vec_t             free_pick;
  way_vec_t             rr_pick;
  logic                 use_ptr;

  // Unlocked ways that hold nothing
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      free_vec[w] = ~spm_lock_i[w] & ~rdata_i[w].valid;
    end
  end

  // Lowest set bit of the free mask
  assign free_pick = free_vec & (~free_vec + way_vec_t'(1));

  // First unlocked way at or after the pointer, with wrap
  always_comb begin
    int unsigned cand;
    cand     = 0;
    rr_found = 1'b0;
    rr_idx   = '0;
    for (int unsigned k = 0; k < num_ways; k++) begin
      cand = (ptr_q + k) % num_ways;
      if (!rr_found && !spm_lock_i[cand]) begin
        rr_found = 1'b1;
        rr_idx   = ptr_width'(cand);
      end
    end
  end

  assign rr_pick  = rr_found ? (way_vec_t'(1) << rr_idx) : '0;
  assign use_ptr  = ~|free_vec;
  assign victim_o = use_ptr ? rr_pick : free_pick;

  // Pointer moves past the victim only when it made the choice
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (commit_i && miss_i && use_ptr && rr_found) begin
      ptr_q <= (rr_idx == ptr_width'(num_ways - 1)) ? '0 : rr_idx + 1'b1;
    end
  end

endmodule

// File: logic/tag_compare.sv
// Hit detection and write-back forming, purely combinational; flush ignores the SPM lock mask
module tag_compare
  import tag_store_cfg_pkg::*;
  import tag_store_types_pkg::*;
(
  input  tag_req_t       req_q_i,
  input  tag_entry_vec_t rdata_i,
  input  way_vec_t       spm_lock_i,
  input  way_vec_t       victim_i,
  input  logic           commit_i,
  output tag_res_t       res_o,
  output logic           miss_o,
  output way_vec_t       wr_en_o,
  output index_t         wr_index_o,
  output tag_entry_t     wdata_o
);

  way_vec_t   hit_vec;
  way_vec_t   wr_way;
  tag_entry_t hit_entry;
  tag_entry_t victim_entry;
  tag_entry_t flush_entry;

  // AND-OR mux of the entries under a one-hot select
  function automatic tag_entry_t pick_entry(tag_entry_vec_t entries, way_vec_t sel);
    tag_entry_t acc;
    acc = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (sel[w]) begin
        acc = acc | entries[w];
      end
    end
    return acc;
  endfunction

  // Locked ways serve as scratchpad and never hit
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      hit_vec[w] = ~spm_lock_i[w] & rdata_i[w].valid & (rdata_i[w].tag == req_q_i.tag);
    end
  end

  assign hit_entry    = pick_entry(rdata_i, hit_vec);
  assign victim_entry = pick_entry(rdata_i, victim_i);
  assign flush_entry  = pick_entry(rdata_i, req_q_i.way);

  always_comb begin
    res_o   = '0;
    miss_o  = 1'b0;
    wr_way  = '0;
    wdata_o = '0;
    if (req_q_i.mode == mode_flush) begin
      // Report the named way, then write it back as all zero
      res_o.way       = req_q_i.way;
      res_o.evict     = flush_entry.valid & flush_entry.dirty;
      res_o.evict_tag = flush_entry.valid ? flush_entry.tag : '0;
      wr_way          = req_q_i.way;
    end else if (|hit_vec) begin
      res_o.way = hit_vec;
      res_o.hit = 1'b1;
      // Rewrite only for a dirty request on a clean line
      if (req_q_i.dirty && !hit_entry.dirty) begin
        wr_way = hit_vec;
      end
      wdata_o = '{valid: 1'b1, dirty: 1'b1, tag: req_q_i.tag};
    end else begin
      miss_o          = 1'b1;
      res_o.way       = victim_i;
      res_o.evict     = victim_entry.valid & victim_entry.dirty;
      // Invalid entries carry no meaningful tag
      res_o.evict_tag = victim_entry.valid ? victim_entry.tag : '0;
      wr_way          = victim_i;
      wdata_o         = '{valid: 1'b1, dirty: req_q_i.dirty, tag: req_q_i.tag};
    end
  end

  assign wr_en_o    = commit_i ? wr_way : '0;
  assign wr_index_o = req_q_i.index;

endmodule

// File: logic/tag_way_array.sv
// Per-way tag memories, read_latency of 1 or more; a read and a write never share a set cycle
module tag_way_array
  import tag_store_cfg_pkg::*;
  import tag_store_types_pkg::*;
#(
  parameter int unsigned read_latency = 1
) (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           rd_en_i,
  input  way_vec_t       wr_en_i,
  input  index_t         index_i,
  input  index_t         wr_index_i,
  input  tag_entry_t     wdata_i,
  output tag_entry_vec_t rdata_o,
  output logic           rvalid_o
);

  localparam int unsigned num_sets = 1 << index_width;

  // Memory word without the valid bit, which lives in flops
  typedef struct packed {
    logic dirty;
    tag_t tag;
  } stored_t;

  tag_entry_vec_t                rd_word;
  tag_entry_vec_t                data_q [read_latency];
  logic [read_latency-1:0]       token_q;

  for (genvar w = 0; w < num_ways; w++) begin : gen_way
    stored_t             mem_q [num_sets];
    logic [num_sets-1:0] valid_q;

    always_ff @(posedge clk_i) begin
      if (wr_en_i[w]) begin
        mem_q[wr_index_i] <= '{dirty: wdata_i.dirty, tag: wdata_i.tag};
      end
    end

    // Valid bits clear on reset so every set starts empty
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        valid_q <= '0;
      end else if (wr_en_i[w]) begin
        valid_q[wr_index_i] <= wdata_i.valid;
      end
    end

    assign rd_word[w] = '{
      valid: valid_q[index_i],
      dirty: mem_q[index_i].dirty,
      tag:   mem_q[index_i].tag
    };
  end

  // Each stage moves only behind its token
  // The last stage keeps the entries until the next read arrives
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      data_q[0] <= rd_word;
    end
    for (int s = 1; s < read_latency; s++) begin
      if (token_q[s-1]) begin
        data_q[s] <= data_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      token_q <= '0;
    end else begin
      token_q[0] <= rd_en_i;
      for (int s = 1; s < read_latency; s++) begin
        token_q[s] <= token_q[s-1];
      end
    end
  end

  assign rdata_o  = data_q[read_latency-1];
  assign rvalid_o = token_q[read_latency-1];

endmodule

// File: logic/tag_store_ctrl.sv
// Tag store sequencer; accepts only when idle and the host holds req_i while valid_i waits
module tag_store_ctrl
  import tag_store_types_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  tag_req_t req_i,
  input  logic     valid_i,
  output logic     ready_o,
  output logic     rd_en_o,
  output index_t   rd_index_o,
  input  logic     rvalid_i,
  output tag_req_t req_q_o,
  output logic     push_o,
  input  logic     push_ready_i,
  output logic     commit_o
);

  // Idle takes a request, reading waits for the array token,
  // presenting keeps pushing while the result buffer is full
  typedef enum logic [1:0] {
    st_idle,
    st_reading,
    st_presenting
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  tag_req_t    req_q;
  logic        accept;

  // Ready only in idle, so it drops the cycle after an accept
  assign ready_o = (state_q == st_idle);
  assign accept  = valid_i & ready_o;

  // Read goes out in the accept cycle straight from the request
  assign rd_en_o    = accept;
  assign rd_index_o = req_i.index;

  // Result is ready once the token arrives
  // After that the array output is held, so pushing may continue in presenting
  assign push_o = ((state_q == st_reading) & rvalid_i) | (state_q == st_presenting);

  // Write-back, pointer update and buffer entry all share this strobe
  assign commit_o = push_o & push_ready_i;

  assign req_q_o = req_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      st_idle: begin
        if (accept) begin
          state_d = st_reading;
        end
      end
      st_reading: begin
        // Straight back to idle when the buffer takes the result at once
        if (rvalid_i) begin
          state_d = commit_o ? st_idle : st_presenting;
        end
      end
      st_presenting: begin
        if (commit_o) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Request copy for the compare and write-back stages
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

endmodule

// File: logic/tag_store_types_pkg.sv
// Tag store data types built from the geometry package; field order fixes the packed layout
package tag_store_types_pkg;
  import tag_store_cfg_pkg::*;

  // One bit per way
  // Used as a one-hot way select and as a per-way flag mask
  typedef logic [num_ways-1:0] way_vec_t;

  // Set index that also serves as the memory address
  typedef logic [index_width-1:0] index_t;

  // Tag value as compared and stored
  typedef logic [tag_width-1:0] tag_t;

  // Operation carried by a request
  typedef enum logic {
    mode_lookup = 1'b0,
    mode_flush  = 1'b1
  } tag_mode_e;

  // Word held per way and set
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  // One entry per way with way 0 in the low bits
  typedef tag_entry_t [num_ways-1:0] tag_entry_vec_t;

  // Request from the host
  // way is the one-hot flush target and is ignored on a lookup
  typedef struct packed {
    tag_mode_e mode;
    index_t    index;
    tag_t      tag;
    logic      dirty;
    way_vec_t  way;
  } tag_req_t;

  // Response toward the host
  typedef struct packed {
    way_vec_t way;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } tag_res_t;

endpackage

// File: logic/tag_store_cfg_pkg.sv
// Cache geometry for the tag store; num_ways must be at least 2 and every width non-zero
package tag_store_cfg_pkg;

  // Associativity of the cache
  // Sets the number of tag memories and the width of every way vector
  localparam int unsigned num_ways = 4;

  // Set index bits for 2**index_width sets per way
  localparam int unsigned index_width = 6;

  // Stored tag bits
  // The line offset and the index are not part of this field
  localparam int unsigned tag_width = 10;

endpackage
